/* tb.f */
debug_pkg.sv
debug_command_ctrl.sv
instr_word_assembler.sv
dump_sequencer.sv
tx_word_serializer.sv
debug_unit.sv
tb_debug_unit.sv

/* Bender.yml */
package:
  name: debug_unit

sources:
  - debug_pkg.sv
  - debug_command_ctrl.sv
  - instr_word_assembler.sv
  - dump_sequencer.sv
  - tx_word_serializer.sv
  - debug_unit.sv
  - target: test
    files:
      - tb_debug_unit.sv

/* tb_debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit;

    localparam int CLK_PERIOD      = 10;
    localparam int RANDOM_SEED     = 32'he474ec48;
    localparam int DUMP_WORDS      = 2 + debug_pkg::NUM_REGS + debug_pkg::NUM_DMEM_WORDS;
    localparam int DUMP_BYTES      = DUMP_WORDS * debug_pkg::BYTES_PER_WORD;
    localparam int NUM_DUMPS       = 4;
    localparam int BYTE_CYCLES_MAX = 12;    // offer, up to 6 busy cycles, word reload
    localparam int MAX_LOAD_WORDS  = 8;
    localparam int LOAD_BYTES_MAX  = 2 * debug_pkg::BYTES_PER_WORD * (MAX_LOAD_WORDS + 2);
    localparam int RX_BYTE_CYCLES  = 4;
    localparam int RUN_CYCLES      = 40;
    localparam int IDLE_CYCLES     = 30;
    localparam int MARGIN_CYCLES   = 2000;
    localparam int WATCHDOG_CYCLES = NUM_DUMPS * DUMP_BYTES * BYTE_CYCLES_MAX
                                     + LOAD_BYTES_MAX * RX_BYTE_CYCLES
                                     + RUN_CYCLES + MARGIN_CYCLES;

    logic                  i_clk;
    logic                  i_reset;
    logic                  i_uart_rx_flag_ready;
    debug_pkg::byte_t      i_uart_rx_data;
    logic                  i_uart_tx_done;
    logic                  i_halt;
    debug_pkg::word_t      i_mips_pc;
    debug_pkg::word_t      i_clk_wiz_count;
    debug_pkg::word_t      i_data_bankregisters;
    debug_pkg::word_t      i_data_mem;
    logic                  o_uart_rx_reset;
    logic                  o_flag_tx_ready;
    debug_pkg::byte_t      o_uart_tx_data;
    logic                  o_ctl_clk_wiz;
    debug_pkg::reg_addr_t  o_select_addr_registers;
    debug_pkg::dmem_addr_t o_select_addr_memdata;
    logic                  o_flag_instr_write;
    debug_pkg::word_t      o_dato_mem_instruction;
    debug_pkg::imem_addr_t o_select_addr_mem_instr;

    // core model state
    debug_pkg::word_t pc;
    debug_pkg::word_t cycle_count;
    debug_pkg::word_t regs [debug_pkg::NUM_REGS];
    debug_pkg::word_t mem  [debug_pkg::NUM_DMEM_WORDS];
    logic             run_sample;
    logic             rx_ack_q;
    logic             reset_q;

    debug_pkg::byte_t tx_bytes [$];
    debug_pkg::word_t exp_words [$];
    int               bytes_seen;
    int               writes_seen;
    int               load_index;
    int               clk_en_cycles;
    int               value_errors;
    int               other_errors;
    int unsigned      hold_cycles;
    int unsigned      seed_ret;

    debug_unit dut (
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_uart_rx_flag_ready    (i_uart_rx_flag_ready),
        .i_uart_rx_data          (i_uart_rx_data),
        .i_uart_tx_done          (i_uart_tx_done),
        .i_halt                  (i_halt),
        .i_mips_pc               (i_mips_pc),
        .i_clk_wiz_count         (i_clk_wiz_count),
        .i_data_bankregisters    (i_data_bankregisters),
        .i_data_mem              (i_data_mem),
        .o_uart_rx_reset         (o_uart_rx_reset),
        .o_flag_tx_ready         (o_flag_tx_ready),
        .o_uart_tx_data          (o_uart_tx_data),
        .o_ctl_clk_wiz           (o_ctl_clk_wiz),
        .o_select_addr_registers (o_select_addr_registers),
        .o_select_addr_memdata   (o_select_addr_memdata),
        .o_flag_instr_write      (o_flag_instr_write),
        .o_dato_mem_instruction  (o_dato_mem_instruction),
        .o_select_addr_mem_instr (o_select_addr_mem_instr)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    assign i_mips_pc            = pc;
    assign i_clk_wiz_count      = cycle_count;
    assign i_data_bankregisters = regs[o_select_addr_registers];  // combinational read port
    assign i_data_mem           = mem[o_select_addr_memdata];

    // dump order is pc, cycles, registers, memory, msb first
    function automatic debug_pkg::byte_t expected_dump_byte(input int index);
        int               word_idx;
        int               byte_idx;
        debug_pkg::word_t w;
        word_idx = index / debug_pkg::BYTES_PER_WORD;
        byte_idx = index % debug_pkg::BYTES_PER_WORD;
        if (word_idx == 0) begin
            w = pc;
        end else if (word_idx == 1) begin
            w = cycle_count;
        end else if (word_idx < 2 + debug_pkg::NUM_REGS) begin
            w = regs[word_idx - 2];
        end else begin
            w = mem[word_idx - 2 - debug_pkg::NUM_REGS];
        end
        return w[31 - 8 * byte_idx -: 8];
    endfunction

    task automatic check_byte(input string name, input debug_pkg::byte_t got,
                              input debug_pkg::byte_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input debug_pkg::word_t got,
                              input debug_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_imem_addr(input string name, input debug_pkg::imem_addr_t got,
                                   input debug_pkg::imem_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        if (cond !== 1'b1) begin
            other_errors++;
            $display("at %0t ns: %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // uart receiver model, flag held until the ack is seen
    task automatic send_rx_byte(input debug_pkg::byte_t b);
        @(negedge i_clk);
        i_uart_rx_flag_ready = 1'b1;
        i_uart_rx_data       = b;
        @(negedge i_clk);
        while (!o_uart_rx_reset) @(negedge i_clk);
        i_uart_rx_flag_ready = 1'b0;
    endtask

    task automatic send_word(input debug_pkg::word_t w);
        int i;
        for (i = debug_pkg::BYTES_PER_WORD - 1; i >= 0; i--) begin
            send_rx_byte(w[8 * i +: 8]);
        end
    endtask

    task automatic load_program(input int n_words);
        int               i;
        int               writes0;
        debug_pkg::word_t w;
        writes0 = writes_seen;
        send_rx_byte(debug_pkg::CMD_LOAD);
        for (i = 0; i <= n_words; i++) begin
            if (i == n_words) begin
                w = debug_pkg::HALT_WORD;
            end else begin
                w = $urandom;
                if (w == debug_pkg::HALT_WORD) w = '0;
            end
            exp_words.push_back(w);
            send_word(w);
        end
        while (exp_words.size() > 0) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        check_word("instruction write count", debug_pkg::word_t'(writes_seen - writes0),
                   debug_pkg::word_t'(n_words + 1));
    endtask

    task automatic wait_dump(input int start);
        while (bytes_seen < start + DUMP_BYTES) @(negedge i_clk);
        repeat (IDLE_CYCLES) @(negedge i_clk);
        check_word("dump byte count", debug_pkg::word_t'(bytes_seen - start),
                   debug_pkg::word_t'(DUMP_BYTES));
        check_condition(!o_flag_tx_ready, "transmit still active after the dump");
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        int en0;
        int wr0;
        int tx0;
        en0 = clk_en_cycles;
        wr0 = writes_seen;
        tx0 = bytes_seen;
        repeat (cycles) @(negedge i_clk);
        check_condition(clk_en_cycles == en0, {"clock enable seen ", what});
        check_condition(writes_seen == wr0, {"instruction write seen ", what});
        check_condition(bytes_seen == tx0, {"byte transmitted ", what});
    endtask

    // clock enable sampled at the edge, core retires half a cycle later
    always @(posedge i_clk) begin
        run_sample <= !i_reset && o_ctl_clk_wiz;
        if (!i_reset && o_ctl_clk_wiz) clk_en_cycles++;
    end

    // the receive ack drops after one cycle
    always @(posedge i_clk) begin
        if (!i_reset && !reset_q && rx_ack_q && o_uart_rx_reset) begin
            other_errors++;
            $display("at %0t ns: o_uart_rx_reset stayed high for more than one cycle", $time);
        end
        rx_ack_q <= o_uart_rx_reset;
        reset_q  <= i_reset;
    end

    always @(negedge i_clk) begin
        if (run_sample) begin
            regs[cycle_count[4:0]] = regs[cycle_count[4:0]] ^ pc;
            mem[cycle_count[3:0]]  = pc + cycle_count;
            pc                     = pc + 32'd4;
            cycle_count            = cycle_count + 32'd1;
        end
    end

    // uart transmitter model with random busy time
    always begin
        @(negedge i_clk);
        if (!i_reset && o_flag_tx_ready && i_uart_tx_done) begin
            tx_bytes.push_back(o_uart_tx_data);
            i_uart_tx_done = 1'b0;
            hold_cycles    = 1 + ($urandom % 6);
            repeat (hold_cycles) @(negedge i_clk);
            i_uart_tx_done = 1'b1;
        end
    end

    always @(posedge i_clk) begin
        while (tx_bytes.size() > 0) begin
            check_byte($sformatf("o_uart_tx_data byte %0d", bytes_seen % DUMP_BYTES),
                       tx_bytes.pop_front(), expected_dump_byte(bytes_seen % DUMP_BYTES));
            bytes_seen++;
        end
    end

    always @(negedge i_clk) begin
        if (!i_reset && o_flag_instr_write) begin
            writes_seen++;
            if (exp_words.size() == 0) begin
                other_errors++;
                $display("at %0t ns: instruction write with no word loaded", $time);
            end else begin
                check_word("o_dato_mem_instruction", o_dato_mem_instruction, exp_words[0]);
                check_imem_addr("o_select_addr_mem_instr", o_select_addr_mem_instr,
                                debug_pkg::imem_addr_t'(load_index * debug_pkg::INSTR_ADDR_STEP));
                load_index++;
                if (exp_words.pop_front() == debug_pkg::HALT_WORD) load_index = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        other_errors++;
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run();
    end

    initial begin
        int i;
        int start;
        int en0;
        seed_ret             = $urandom(RANDOM_SEED);
        i_clk                = 1'b0;
        i_reset              = 1'b1;
        i_uart_rx_flag_ready = 1'b0;
        i_uart_rx_data       = '0;
        i_uart_tx_done       = 1'b1;
        i_halt               = 1'b0;
        run_sample           = 1'b0;
        rx_ack_q             = 1'b0;
        reset_q              = 1'b1;
        pc                   = 32'h0040_0000;
        cycle_count          = '0;
        for (i = 0; i < debug_pkg::NUM_REGS; i++) regs[i] = $urandom;
        for (i = 0; i < debug_pkg::NUM_DMEM_WORDS; i++) mem[i] = $urandom;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        check_condition(o_uart_rx_reset, "o_uart_rx_reset low during reset");
        i_reset = 1'b0;

        for (i = 0; i < 20; i++) begin
            check_condition(!o_ctl_clk_wiz && !o_flag_tx_ready && !o_flag_instr_write,
                            "an output is active after reset");
            @(negedge i_clk);
        end
        check_condition(bytes_seen == 0, "byte transmitted before any command");

        send_rx_byte(8'h41);        // not a command
        expect_quiet(20, "after an unknown byte in idle");

        load_program(3 + ($urandom % 6));
        load_program(3 + ($urandom % 6));   // address starts over at 0

        // continuous run until halt
        en0 = clk_en_cycles;
        send_rx_byte(debug_pkg::CMD_CONTINUOUS);
        for (i = 0; i < RUN_CYCLES; i++) begin
            @(negedge i_clk);
            check_condition(o_ctl_clk_wiz, "clock enable low in continuous mode");
        end
        start  = bytes_seen;
        i_halt = 1'b1;
        wait_dump(start);
        check_word("o_ctl_clk_wiz high cycles", debug_pkg::word_t'(clk_en_cycles - en0),
                   debug_pkg::word_t'(RUN_CYCLES));
        @(negedge i_clk);
        i_halt = 1'b0;
        expect_quiet(20, "after the halt dump");

        // step mode, one enable per 'n'
        en0 = clk_en_cycles;
        send_rx_byte(debug_pkg::CMD_STEP);
        expect_quiet(20, "in step mode before 'n'");
        for (i = 1; i <= 2; i++) begin
            start = bytes_seen;
            send_rx_byte(debug_pkg::CMD_NEXT);
            wait_dump(start);
            check_word("o_ctl_clk_wiz high cycles", debug_pkg::word_t'(clk_en_cycles - en0),
                       debug_pkg::word_t'(i));
            send_rx_byte(8'h78);
            expect_quiet(20, "after an unknown byte in step mode");
        end

        // halt seen while stepping ends in idle
        start = bytes_seen;
        en0   = clk_en_cycles;
        @(negedge i_clk);
        i_halt = 1'b1;
        wait_dump(start);
        check_condition(clk_en_cycles == en0, "clock enable during the halt dump");
        @(negedge i_clk);
        i_halt = 1'b0;
        send_rx_byte(debug_pkg::CMD_NEXT);  // ignored in idle
        expect_quiet(20, "after 'n' in idle");

        repeat (10) @(negedge i_clk);
        finish_run();
    end

endmodule

`default_nettype wire

/* debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_uart_rx_flag_ready,
    input  debug_pkg::byte_t        i_uart_rx_data,
    input  logic                    i_uart_tx_done,
    input  logic                    i_halt,
    input  debug_pkg::word_t        i_mips_pc,
    input  debug_pkg::word_t        i_clk_wiz_count,
    input  debug_pkg::word_t        i_data_bankregisters,
    input  debug_pkg::word_t        i_data_mem,
    output logic                    o_uart_rx_reset,
    output logic                    o_flag_tx_ready,
    output debug_pkg::byte_t        o_uart_tx_data,
    output logic                    o_ctl_clk_wiz,
    output debug_pkg::reg_addr_t    o_select_addr_registers,
    output debug_pkg::dmem_addr_t   o_select_addr_memdata,
    output logic                    o_flag_instr_write,
    output debug_pkg::word_t        o_dato_mem_instruction,
    output debug_pkg::imem_addr_t   o_select_addr_mem_instr
);

    logic               load_byte_valid;
    debug_pkg::byte_t   load_byte;
    logic               load_end;
    logic               dump_start;
    logic               dump_done;
    logic               word_load;
    debug_pkg::word_t   word;
    logic               ser_busy;

    debug_command_ctrl u_command_ctrl (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_uart_rx_flag_ready (i_uart_rx_flag_ready),
        .i_uart_rx_data       (i_uart_rx_data),
        .i_halt               (i_halt),
        .i_load_end           (load_end),
        .i_dump_done          (dump_done),
        .o_uart_rx_reset      (o_uart_rx_reset),
        .o_load_byte_valid    (load_byte_valid),
        .o_load_byte          (load_byte),
        .o_dump_start         (dump_start),
        .o_ctl_clk_wiz        (o_ctl_clk_wiz)
    );

    instr_word_assembler u_instr_word_assembler (
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_byte_valid            (load_byte_valid),
        .i_byte                  (load_byte),
        .o_flag_instr_write      (o_flag_instr_write),
        .o_dato_mem_instruction  (o_dato_mem_instruction),
        .o_select_addr_mem_instr (o_select_addr_mem_instr),
        .o_load_end              (load_end)
    );

    dump_sequencer u_dump_sequencer (
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_start                 (dump_start),
        .i_mips_pc               (i_mips_pc),
        .i_clk_wiz_count         (i_clk_wiz_count),
        .i_data_bankregisters    (i_data_bankregisters),
        .i_data_mem              (i_data_mem),
        .i_ser_busy              (ser_busy),
        .o_select_addr_registers (o_select_addr_registers),
        .o_select_addr_memdata   (o_select_addr_memdata),
        .o_word_load             (word_load),
        .o_word                  (word),
        .o_done                  (dump_done)
    );

    tx_word_serializer u_tx_word_serializer (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_word_load     (word_load),
        .i_word          (word),
        .i_uart_tx_done  (i_uart_tx_done),
        .o_busy          (ser_busy),
        .o_flag_tx_ready (o_flag_tx_ready),
        .o_uart_tx_data  (o_uart_tx_data)
    );

endmodule

`default_nettype wire

/* tx_word_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_word_serializer (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_word_load,
    input  debug_pkg::word_t    i_word,
    input  logic                i_uart_tx_done,
    output logic                o_busy,
    output logic                o_flag_tx_ready,
    output debug_pkg::byte_t    o_uart_tx_data
);

    typedef enum logic [1:0] {
        T_IDLE,
        T_OFFER,    // byte offered, uart not yet started
        T_WAIT      // uart busy with the byte
    } state_t;

    state_t                                       state;
    debug_pkg::word_t                             word_q;
    logic [$clog2(debug_pkg::BYTES_PER_WORD)-1:0] byte_cnt;
    logic                                         last_byte;

    assign last_byte      = (byte_cnt == $bits(byte_cnt)'(debug_pkg::BYTES_PER_WORD - 1));
    assign o_busy         = (state != T_IDLE);
    assign o_uart_tx_data = word_q[$bits(debug_pkg::word_t)-1 -: $bits(debug_pkg::byte_t)];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state           <= T_IDLE;
            byte_cnt        <= '0;
            o_flag_tx_ready <= 1'b0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (i_word_load) begin
                        byte_cnt        <= '0;
                        o_flag_tx_ready <= 1'b1;
                        state           <= T_OFFER;
                    end
                end
                T_OFFER: begin
                    if (!i_uart_tx_done) begin
                        o_flag_tx_ready <= 1'b0;
                        state           <= T_WAIT;
                    end
                end
                T_WAIT: begin
                    if (i_uart_tx_done) begin
                        if (last_byte) begin
                            state <= T_IDLE;
                        end else begin
                            byte_cnt        <= byte_cnt + 1'b1;
                            o_flag_tx_ready <= 1'b1;
                            state           <= T_OFFER;
                        end
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == T_IDLE && i_word_load) begin
            word_q <= i_word;
        end else if (state == T_WAIT && i_uart_tx_done && !last_byte) begin
            word_q <= word_q << $bits(debug_pkg::byte_t);   // next byte to the top
        end
    end

    a_tx_data_stable: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_flag_tx_ready && $past(o_flag_tx_ready)) |-> $stable(o_uart_tx_data)
    );

endmodule

`default_nettype wire

/* dump_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_start,
    input  debug_pkg::word_t        i_mips_pc,
    input  debug_pkg::word_t        i_clk_wiz_count,
    input  debug_pkg::word_t        i_data_bankregisters,
    input  debug_pkg::word_t        i_data_mem,
    input  logic                    i_ser_busy,
    output debug_pkg::reg_addr_t    o_select_addr_registers,
    output debug_pkg::dmem_addr_t   o_select_addr_memdata,
    output logic                    o_word_load,
    output debug_pkg::word_t        o_word,
    output logic                    o_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PC,
        S_CYCLES,
        S_REGS,
        S_MEM,
        S_DRAIN
    } state_t;

    state_t state;
    logic   can_load;
    logic   last_reg;
    logic   last_mem;

    // busy rises one cycle late, so a pending strobe also blocks
    assign can_load = !i_ser_busy && !o_word_load;
    assign last_reg = (o_select_addr_registers ==
                       debug_pkg::reg_addr_t'(debug_pkg::NUM_REGS - 1));
    assign last_mem = (o_select_addr_memdata ==
                       debug_pkg::dmem_addr_t'(debug_pkg::NUM_DMEM_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state                   <= S_IDLE;
            o_select_addr_registers <= '0;
            o_select_addr_memdata   <= '0;
            o_word_load             <= 1'b0;
            o_done                  <= 1'b0;
        end else begin
            o_word_load <= 1'b0;
            o_done      <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state <= S_PC;
                    end
                end
                S_PC: begin
                    if (can_load) begin
                        o_word_load <= 1'b1;
                        state       <= S_CYCLES;
                    end
                end
                S_CYCLES: begin
                    if (can_load) begin
                        o_word_load <= 1'b1;
                        state       <= S_REGS;
                    end
                end
                S_REGS: begin
                    if (can_load) begin
                        o_word_load             <= 1'b1;
                        o_select_addr_registers <= o_select_addr_registers + 1'b1;  // wraps to 0
                        if (last_reg) begin
                            state <= S_MEM;
                        end
                    end
                end
                S_MEM: begin
                    if (can_load) begin
                        o_word_load           <= 1'b1;
                        o_select_addr_memdata <= o_select_addr_memdata + 1'b1;
                        if (last_mem) begin
                            state <= S_DRAIN;
                        end
                    end
                end
                S_DRAIN: begin
                    if (can_load) begin     // last byte has left the serializer
                        o_done <= 1'b1;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (can_load) begin
            case (state)
                S_PC:     o_word <= i_mips_pc;
                S_CYCLES: o_word <= i_clk_wiz_count;
                S_REGS:   o_word <= i_data_bankregisters;
                S_MEM:    o_word <= i_data_mem;
                default:  o_word <= o_word;
            endcase
        end
    end

    a_load_when_idle: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_word_load |-> !i_ser_busy
    );

endmodule

`default_nettype wire

/* instr_word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_word_assembler (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_byte_valid,
    input  debug_pkg::byte_t        i_byte,
    output logic                    o_flag_instr_write,
    output debug_pkg::word_t        o_dato_mem_instruction,
    output debug_pkg::imem_addr_t   o_select_addr_mem_instr,
    output logic                    o_load_end
);

    logic [$clog2(debug_pkg::BYTES_PER_WORD)-1:0] byte_cnt;
    logic                                         last_byte;

    assign last_byte = (byte_cnt == $bits(byte_cnt)'(debug_pkg::BYTES_PER_WORD - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt                <= '0;
            o_flag_instr_write      <= 1'b0;
            o_select_addr_mem_instr <= '0;
            o_load_end              <= 1'b0;
        end else begin
            o_flag_instr_write <= 1'b0;
            o_load_end         <= 1'b0;
            if (i_byte_valid) begin
                byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
                if (last_byte) begin
                    o_flag_instr_write <= 1'b1;     // word complete
                end
            end
            if (o_flag_instr_write) begin
                if (o_dato_mem_instruction == debug_pkg::HALT_WORD) begin
                    o_select_addr_mem_instr <= '0;      // next load starts over
                    o_load_end              <= 1'b1;
                end else begin
                    o_select_addr_mem_instr <= o_select_addr_mem_instr
                                               + debug_pkg::INSTR_ADDR_STEP;
                end
            end
        end
    end

    // msb arrives first
    always_ff @(posedge i_clk) begin
        if (i_byte_valid) begin
            o_dato_mem_instruction <= {
                o_dato_mem_instruction[$bits(debug_pkg::word_t)-$bits(debug_pkg::byte_t)-1:0],
                i_byte
            };
        end
    end

    a_write_single_cycle: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_flag_instr_write |=> !o_flag_instr_write
    );

endmodule

`default_nettype wire

/* debug_command_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_command_ctrl (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_uart_rx_flag_ready,
    input  debug_pkg::byte_t     i_uart_rx_data,
    input  logic                 i_halt,
    input  logic                 i_load_end,
    input  logic                 i_dump_done,
    output logic                 o_uart_rx_reset,
    output logic                 o_load_byte_valid,
    output debug_pkg::byte_t     o_load_byte,
    output logic                 o_dump_start,
    output logic                 o_ctl_clk_wiz
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONT,
        ST_STEP,
        ST_LOAD,
        ST_DUMP
    } state_t;

    state_t state;
    logic   step_pulse;     // single clock enable in step mode
    logic   ret_step;       // go back to step mode once the dump is out
    logic   can_accept;
    logic   accept;

    always_comb begin
        case (state)
            ST_IDLE: can_accept = 1'b1;
            ST_STEP: can_accept = !step_pulse && !i_halt;
            ST_LOAD: can_accept = !i_load_end;
            default: can_accept = 1'b0;     // bytes wait in the uart
        endcase
    end

    assign accept = i_uart_rx_flag_ready && !o_uart_rx_reset && can_accept;

    // halt freezes the core at once
    assign o_ctl_clk_wiz = ((state == ST_CONT) || step_pulse) && !i_halt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state             <= ST_IDLE;
            o_uart_rx_reset   <= 1'b1;
            o_load_byte_valid <= 1'b0;
            o_dump_start      <= 1'b0;
            step_pulse        <= 1'b0;
            ret_step          <= 1'b0;
        end else begin
            o_uart_rx_reset   <= accept;    // one cycle ack, uart drops its flag
            o_load_byte_valid <= 1'b0;
            o_dump_start      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (i_uart_rx_data)
                            debug_pkg::CMD_CONTINUOUS: state <= ST_CONT;
                            debug_pkg::CMD_STEP:       state <= ST_STEP;
                            debug_pkg::CMD_LOAD:       state <= ST_LOAD;
                            default:                   state <= ST_IDLE;
                        endcase
                    end
                end
                ST_CONT: begin
                    if (i_halt) begin
                        ret_step     <= 1'b0;
                        o_dump_start <= 1'b1;
                        state        <= ST_DUMP;
                    end
                end
                ST_STEP: begin
                    if (i_halt) begin
                        step_pulse   <= 1'b0;
                        ret_step     <= 1'b0;
                        o_dump_start <= 1'b1;
                        state        <= ST_DUMP;
                    end else if (step_pulse) begin
                        step_pulse   <= 1'b0;
                        ret_step     <= 1'b1;
                        o_dump_start <= 1'b1;
                        state        <= ST_DUMP;
                    end else if (accept && i_uart_rx_data == debug_pkg::CMD_NEXT) begin
                        step_pulse   <= 1'b1;
                    end
                end
                ST_LOAD: begin
                    o_load_byte_valid <= accept;
                    if (i_load_end) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DUMP: begin
                    if (i_halt) begin
                        ret_step <= 1'b0;   // core stopped during the step
                    end
                    if (i_dump_done) begin
                        state <= (ret_step && !i_halt) ? ST_STEP : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_load_byte <= i_uart_rx_data;
        end
    end

    // the loader and the dump never overlap
    a_no_dump_in_load: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (state == ST_LOAD) |-> !o_dump_start && !i_dump_done
    );

endmodule

`default_nettype wire

/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

    typedef logic [31:0] word_t;        // core data word
    typedef logic [7:0]  byte_t;        // uart frame
    typedef logic [4:0]  reg_addr_t;    // register bank index
    typedef logic [3:0]  dmem_addr_t;   // data memory word index
    typedef logic [7:0]  imem_addr_t;   // instruction memory byte address

    localparam int NUM_REGS       = 32;
    localparam int NUM_DMEM_WORDS = 16;
    localparam int BYTES_PER_WORD = 4;

    localparam imem_addr_t INSTR_ADDR_STEP = 8'd4;
    localparam word_t      HALT_WORD       = 32'hffff_ffff;   // last word of a program load

    // command bytes, ascii
    localparam byte_t CMD_CONTINUOUS = 8'h63;  // 'c'
    localparam byte_t CMD_STEP       = 8'h73;  // 's'
    localparam byte_t CMD_NEXT       = 8'h6e;  // 'n'
    localparam byte_t CMD_LOAD       = 8'h64;  // 'd'

endpackage

`default_nettype wire
